// ==== wiscCpu.f ====
+incdir+.
wiscPkg.sv
alu.sv
registerFile.sv
pcControl.sv
memory.sv
cpu.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f wiscCpu.f -o simCpu
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simCpu
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished with status 0"
exit 0

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`include "wiscCpu_settings.svh"

module tb_cpu;

	localparam int NUM_PROGS = 20;
	localparam int PROG_LEN = 40;                                  // Random instructions before HLT
	localparam int CYCLE_LIMIT = NUM_PROGS * (PROG_LEN + 1 + 64);

	logic clk;
	logic reset;
	logic progWrite;
	logic [`WORD_WIDTH-1:0] progAddr;
	logic [`WORD_WIDTH-1:0] progData;
	logic [$clog2(`REG_COUNT)-1:0] dbgReg;
	logic [`WORD_WIDTH-1:0] dbgData;
	logic hlt;
	logic [`WORD_WIDTH-1:0] pc;

	logic [15:0] prog [PROG_LEN+1];
	bit startOk [PROG_LEN+1];     // Safe landing point for a branch
	logic [15:0] mRegs [`REG_COUNT];
	logic [15:0] mMem [`DMEM_DEPTH];
	logic [15:0] mPC;
	logic mZ, mV, mN;             // Reference flags
	int cycleCount;

	cpu u_dut
	(
		.clk(clk), .reset(reset),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.dbgReg(dbgReg), .dbgData(dbgData),
		.hlt(hlt), .pc(pc)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic abortRun(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
			abortRun({name, " does not match the reference model"});
		end
	endtask

	////////////////////////////////////////
	// Reference arithmetic
	////////////////////////////////////////

	// Signed 16-bit clamp that sets ovf when it clamps
	function automatic logic [15:0] clamp16(input int sum, output logic ovf);
		ovf = (sum > 32767) || (sum < -32768);
		if (sum > 32767)
			return 16'h7FFF;
		if (sum < -32768)
			return 16'h8000;
		return sum[15:0];
	endfunction

	function automatic logic [15:0] nibbleAdds(input logic [15:0] a, input logic [15:0] b);
		logic [15:0] r;
		int s;
		for (int k = 0; k < 4; k++)
		begin
			s = int'($signed(a[4*k +: 4])) + int'($signed(b[4*k +: 4]));
			r[4*k +: 4] = (s > 7) ? 4'h7 : ((s < -8) ? 4'h8 : s[3:0]); // -8..7 per lane
		end
		return r;
	endfunction

	function automatic logic [15:0] byteSum(input logic [15:0] a, input logic [15:0] b);
		int s;
		s = int'($signed(a[7:0])) + int'($signed(a[15:8]))
			+ int'($signed(b[7:0])) + int'($signed(b[15:8]));
		return s[15:0]; // Truncation keeps the sign
	endfunction

	function automatic bit condTrue(input logic [2:0] c);
		bit t;
		case (c)
			3'd0: t = !mZ;
			3'd1: t = mZ;
			3'd2: t = !mZ && !mN;
			3'd3: t = mN;
			3'd4: t = mZ || !mN;
			3'd5: t = mN || mZ;
			3'd6: t = mV;
			default: t = 1'b1; // Unconditional
		endcase
		return t;
	endfunction

	// One instruction of the ISA interpreter
	task automatic stepModel();
		logic [15:0] ins, a, b, res, addr, nextPC;
		logic [3:0] rd, rs, rt;
		logic ovf;
		ins = prog[mPC >> 1];
		rd = ins[11:8];
		rs = ins[7:4];
		rt = ins[3:0];
		a = mRegs[rs];
		b = mRegs[rt];
		addr = a + {{11{rt[3]}}, rt, 1'b0}; // Base plus word offset
		nextPC = mPC + 16'd2;
		case (wiscPkg::opcodeE'(ins[15:12]))
			wiscPkg::OP_ADD, wiscPkg::OP_SUB:
			begin
				if (ins[12])
					res = clamp16(int'($signed(a)) - int'($signed(b)), ovf);
				else
					res = clamp16(int'($signed(a)) + int'($signed(b)), ovf);
				mRegs[rd] = res;
				mZ = (res == 16'h0000);
				mV = ovf;
				mN = res[15];
			end
			wiscPkg::OP_XOR:
			begin
				mRegs[rd] = a ^ b;
				mZ = ((a ^ b) == 16'h0000);
			end
			wiscPkg::OP_RED:    mRegs[rd] = byteSum(a, b);  // Flags untouched
			wiscPkg::OP_PADDSB: mRegs[rd] = nibbleAdds(a, b);
			wiscPkg::OP_SLL, wiscPkg::OP_SRA, wiscPkg::OP_ROR:
			begin
				if (ins[13:12] == 2'b00)
					res = a << rt;
				else if (ins[13:12] == 2'b01)
					res = 16'($signed(a) >>> rt);
				else
					res = (rt == 4'd0) ? a : ((a >> rt) | (a << (5'd16 - rt)));
				mRegs[rd] = res;
				mZ = (res == 16'h0000); // Z only
			end
			wiscPkg::OP_LW: mRegs[rd] = mMem[addr >> 1];
			wiscPkg::OP_SW: mMem[addr >> 1] = mRegs[rd];
			wiscPkg::OP_LLB: mRegs[rd][7:0] = ins[7:0];
			wiscPkg::OP_LHB: mRegs[rd][15:8] = ins[7:0];
			wiscPkg::OP_B:
				if (condTrue(ins[11:9]))
					nextPC = mPC + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
			wiscPkg::OP_BR:
				if (condTrue(ins[11:9]))
					nextPC = a;
			wiscPkg::OP_PCS: mRegs[rd] = mPC + 16'd2;
			default: nextPC = mPC; // HLT parks
		endcase
		mPC = nextPC;
	endtask

	////////////////////////////////////////
	// Program generation
	////////////////////////////////////////

	// Random forward target outside any multi-word sequence
	function automatic int pickTarget(input int first);
		int cand [$];
		for (int j = first; j <= PROG_LEN; j++)
			if (startOk[j])
				cand.push_back(j);
		return cand[$urandom_range(cand.size() - 1, 0)];
	endfunction

	task automatic buildProgram();
		int i, j, sel;
		logic [3:0] r, rd;
		logic [15:0] base;
		int bSlots [$];
		int brSlots [$];
		i = 0;
		for (int k = 0; k <= PROG_LEN; k++)
			startOk[k] = 1'b0;
		while (i < PROG_LEN)
		begin
			sel = $urandom_range(11, 0);
			r = 4'($urandom_range(15, 0));
			rd = 4'($urandom_range(15, 0));
			startOk[i] = 1'b1;
			if (sel == 10 && PROG_LEN - i >= 3)
			begin
				base = 16'(2 * (8 + $urandom_range(15, 0))); // Even base keeps offsets in range
				prog[i] = {wiscPkg::OP_LLB, r, base[7:0]};
				prog[i+1] = {wiscPkg::OP_LHB, r, base[15:8]};
				prog[i+2] = {($urandom_range(1, 0) != 0) ? wiscPkg::OP_SW : wiscPkg::OP_LW,
					rd, r, 4'($urandom_range(15, 0))};
				i += 3;
			end
			else if (sel == 11 && PROG_LEN - i >= 3)
			begin
				brSlots.push_back(i); // LLB, LHB, BR filled in below
				i += 3;
			end
			else if (sel == 9)
			begin
				bSlots.push_back(i);
				i++;
			end
			else if (sel == 8)
			begin
				prog[i] = {wiscPkg::OP_PCS, r, 8'h00};
				i++;
			end
			else if (sel >= 4)
			begin
				// ALU group with rt as the shift amount
				prog[i] = {4'($urandom_range(7, 0)), r, rd, 4'($urandom_range(15, 0))};
				i++;
			end
			else
			begin
				prog[i] = {sel[0] ? wiscPkg::OP_LHB : wiscPkg::OP_LLB, r,
					8'($urandom_range(255, 0))};
				i++;
			end
		end
		prog[PROG_LEN] = {wiscPkg::OP_HLT, 12'h000};
		startOk[PROG_LEN] = 1'b1;
		foreach (bSlots[k])
		begin
			i = bSlots[k];
			j = pickTarget(i + 1);
			prog[i] = {wiscPkg::OP_B, 3'($urandom_range(7, 0)), 9'(j - i - 1)};
		end
		foreach (brSlots[k])
		begin
			i = brSlots[k];
			r = 4'($urandom_range(15, 0));
			j = pickTarget(i + 3);
			prog[i] = {wiscPkg::OP_LLB, r, 8'(2 * j)}; // Byte address of word j
			prog[i+1] = {wiscPkg::OP_LHB, r, 8'h00};
			prog[i+2] = {wiscPkg::OP_BR, 3'($urandom_range(7, 0)), 1'b0, r, 4'h0};
		end
	endtask

	////////////////////////////////////////
	// One program from load to register dump
	////////////////////////////////////////

	task automatic runProgram();
		string regName;
		buildProgram();
		for (int i = 0; i <= PROG_LEN; i++)
		begin
			@(posedge clk);
			reset <= 1'b1;       // Load keeps reset high
			progWrite <= 1'b1;
			progAddr <= 16'(i);
			progData <= prog[i];
		end
		@(posedge clk);
		reset <= 1'b0;
		progWrite <= 1'b0;
		for (int k = 0; k < `REG_COUNT; k++)
			mRegs[k] = 16'h0000;
		for (int k = 0; k < `DMEM_DEPTH; k++)
			mMem[k] = 16'h0000;
		{mZ, mV, mN} = 3'b000;
		mPC = 16'h0000;
		@(negedge clk);
		check("pc", pc, 16'h0000);
		check("hlt", 16'(hlt), 16'h0000);
		// Lockstep with the DUT at one instruction per clock
		while (prog[mPC >> 1][15:12] != wiscPkg::OP_HLT)
		begin
			check("pc", pc, mPC);
			check("hlt", 16'(hlt), 16'h0000);
			stepModel();
			@(negedge clk);
		end
		check("pc", pc, mPC);
		check("hlt", 16'(hlt), 16'h0001);
		repeat (5)
		begin
			@(negedge clk);
			check("hlt", 16'(hlt), 16'h0001); // Sticky until reset
			check("pc", pc, mPC);
		end
		for (int r = 0; r < `REG_COUNT; r++)
		begin
			@(posedge clk);
			dbgReg <= 4'(r);
			@(negedge clk);
			regName = $sformatf("dbgData R%0d", r);
			check(regName, dbgData, mRegs[r]);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		dbgReg = '0;
		void'($urandom(16902));
		for (int p = 0; p < NUM_PROGS; p++)
			runProgram();
		$display(">>> PASS");
		$finish;
	end

	// Watchdog over the whole run
	initial
	begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycleCount++;
		end
		abortRun($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
	end

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps
`include "wiscCpu_settings.svh"

module cpu
(
	input logic clk,
	input logic reset,
	input logic progWrite,                   // Boot port, only under reset
	input logic [`WORD_WIDTH-1:0] progAddr,  // Word address
	input logic [`WORD_WIDTH-1:0] progData,
	input logic [$clog2(`REG_COUNT)-1:0] dbgReg,
	output logic [`WORD_WIDTH-1:0] dbgData,
	output logic hlt,
	output logic [`WORD_WIDTH-1:0] pc
);

	wiscPkg::decodeT ctrl;
	wiscPkg::flagsT flags;
	wiscPkg::aluUpdateT aluUpdate;
	logic [`WORD_WIDTH-1:0] instr, nextPC, pcPlus2;
	logic [`WORD_WIDTH-1:0] instAddr;
	logic [`WORD_WIDTH-1:0] srcData1, srcData2, dstData;
	logic [`WORD_WIDTH-1:0] aluB, aluResult;
	logic [`WORD_WIDTH-1:0] memData;

	////////////////////////////////////////
	// PC and flags registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			flags <= '0;
		end
		else
		begin
			pc <= nextPC;
			if (ctrl.setFlags)
				flags <= (flags & ~aluUpdate.mask) | (aluUpdate.flags & aluUpdate.mask);
		end
	end

	assign pcPlus2 = pc + 16'd2; // PCS link value
	assign hlt = ctrl.halt;

	// Boot address owns the port during reset
	assign instAddr = reset ? progAddr : {1'b0, pc[`WORD_WIDTH-1:1]};

	memory #(.DEPTH(`IMEM_DEPTH)) instMem
	(
		.clk(clk),
		.reset(1'b0),                 // Contents survive the boot load
		.enable(1'b1),
		.write(progWrite && reset),
		.addr(instAddr),
		.dataIn(progData),
		.dataOut(instr)
	);

	////////////////////////////////////////
	// Decoder
	////////////////////////////////////////

	always_comb
	begin
		ctrl.srcReg1 = instr[7:4];
		ctrl.srcReg2 = instr[3:0];
		ctrl.dstReg = instr[11:8];
		ctrl.writeReg = 1'b0;
		ctrl.wbSel = wiscPkg::WB_ALU;
		ctrl.aluOp = wiscPkg::aluOpE'(instr[14:12]); // ALU group shares encoding
		ctrl.useImm = 1'b0;
		ctrl.imm = {12'h000, instr[3:0]};            // Shift amount
		ctrl.setFlags = 1'b0;
		ctrl.memEnable = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.isReg = 1'b0;
		ctrl.cond = wiscPkg::condE'(instr[11:9]);
		ctrl.halt = 1'b0;
		case (wiscPkg::opcodeE'(instr[15:12]))
			wiscPkg::OP_ADD, wiscPkg::OP_SUB, wiscPkg::OP_XOR,
			wiscPkg::OP_RED, wiscPkg::OP_PADDSB:
			begin
				ctrl.writeReg = 1'b1;
				ctrl.setFlags = 1'b1; // ALU mask picks the bits
			end
			wiscPkg::OP_SLL, wiscPkg::OP_SRA, wiscPkg::OP_ROR:
			begin
				ctrl.writeReg = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.setFlags = 1'b1;
			end
			wiscPkg::OP_LW, wiscPkg::OP_SW:
			begin
				ctrl.srcReg2 = instr[11:8]; // SW store data
				ctrl.writeReg = !instr[12]; // LW only
				ctrl.wbSel = wiscPkg::WB_MEM;
				ctrl.aluOp = wiscPkg::ALU_ADD; // Base plus offset
				ctrl.useImm = 1'b1;
				ctrl.imm = {{11{instr[3]}}, instr[3:0], 1'b0};
				ctrl.memEnable = 1'b1;
				ctrl.memWrite = instr[12];
			end
			wiscPkg::OP_LLB, wiscPkg::OP_LHB:
			begin
				ctrl.srcReg1 = instr[11:8]; // Keep the other byte
				ctrl.writeReg = 1'b1;
				ctrl.wbSel = instr[12] ? wiscPkg::WB_LHB : wiscPkg::WB_LLB;
			end
			wiscPkg::OP_B:
				ctrl.branch = 1'b1;
			wiscPkg::OP_BR:
			begin
				ctrl.branch = 1'b1;
				ctrl.isReg = 1'b1; // Target in rs, bits 7:4
			end
			wiscPkg::OP_PCS:
			begin
				ctrl.writeReg = 1'b1;
				ctrl.wbSel = wiscPkg::WB_PCS;
			end
			wiscPkg::OP_HLT:
				ctrl.halt = 1'b1;
		endcase
	end

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	registerFile regFile
	(
		.clk(clk), .reset(reset),
		.srcReg1(ctrl.srcReg1), .srcReg2(ctrl.srcReg2), .dstReg(ctrl.dstReg),
		.writeReg(ctrl.writeReg), .dstData(dstData),
		.srcData1(srcData1), .srcData2(srcData2),
		.dbgReg(dbgReg), .dbgData(dbgData)
	);

	assign aluB = ctrl.useImm ? ctrl.imm : srcData2;

	alu aluUnit(.op(ctrl.aluOp), .a(srcData1), .b(aluB), .result(aluResult), .update(aluUpdate));

	memory #(.DEPTH(`DMEM_DEPTH)) dataMem
	(
		.clk(clk),
		.reset(reset),
		.enable(ctrl.memEnable),
		.write(ctrl.memWrite),
		.addr({1'b0, aluResult[`WORD_WIDTH-1:1]}), // Byte sum to word index
		.dataIn(srcData2),
		.dataOut(memData)
	);

	// Write-back select
	always_comb
	begin
		case (ctrl.wbSel)
			wiscPkg::WB_MEM: dstData = memData;
			wiscPkg::WB_LLB: dstData = {srcData1[15:8], instr[7:0]};
			wiscPkg::WB_LHB: dstData = {instr[7:0], srcData1[7:0]};
			wiscPkg::WB_PCS: dstData = pcPlus2;
			default:         dstData = aluResult;
		endcase
	end

	pcControl pcCtrl
	(
		.enable(ctrl.branch), .cond(ctrl.cond), .imm(instr[8:0]), .flags(flags),
		.pc(pc), .target(srcData1), .isReg(ctrl.isReg), .halt(ctrl.halt),
		.nextPC(nextPC)
	);

	// Program store is frozen once the core runs
	assert property (@(posedge clk) progWrite |-> reset)
		else $error("cpu: progWrite outside reset");

endmodule

// ==== memory.sv ====
`timescale 1ns/1ps
`include "wiscCpu_settings.svh"

module memory
#(
	parameter int DEPTH = 256
)
(
	input logic clk,
	input logic reset,
	input logic enable,
	input logic write,
	input logic [`WORD_WIDTH-1:0] addr, // Word address
	input logic [`WORD_WIDTH-1:0] dataIn,
	output logic [`WORD_WIDTH-1:0] dataOut
);

	localparam int ADDR_BITS = $clog2(DEPTH);

	logic [`WORD_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end
		else if (enable && write)
			mem[addr[ADDR_BITS-1:0]] <= dataIn;
	end

	assign dataOut = enable ? mem[addr[ADDR_BITS-1:0]] : '0; // Zero when idle

	// Upper address bits must never alias onto a lower word
	assert property (@(posedge clk) disable iff (reset) enable |-> (addr < DEPTH))
		else $error("memory: address %h out of range", addr);

endmodule

// ==== pcControl.sv ====
`timescale 1ns/1ps
`include "wiscCpu_settings.svh"

module pcControl
(
	input logic enable,
	input wiscPkg::condE cond,
	input logic [8:0] imm,
	input wiscPkg::flagsT flags,
	input logic [`WORD_WIDTH-1:0] pc,
	input logic [`WORD_WIDTH-1:0] target,
	input logic isReg,
	input logic halt,
	output logic [`WORD_WIDTH-1:0] nextPC
);

	logic condMet;
	logic [`WORD_WIDTH-1:0] pcPlus2;
	logic [`WORD_WIDTH-1:0] branchPC;

	always_comb
	begin
		condMet = 1'b0;
		case (cond)
			wiscPkg::CND_NEQ:    condMet = !flags.zero;
			wiscPkg::CND_EQ:     condMet = flags.zero;
			wiscPkg::CND_GT:     condMet = !flags.zero && !flags.negative;
			wiscPkg::CND_LT:     condMet = flags.negative;
			wiscPkg::CND_GTE:    condMet = flags.zero || !flags.negative;
			wiscPkg::CND_LTE:    condMet = flags.negative || flags.zero;
			wiscPkg::CND_OVFL:   condMet = flags.overflow;
			wiscPkg::CND_UNCOND: condMet = 1'b1;
		endcase
	end

	assign pcPlus2 = pc + 16'd2;
	// Word offset to byte offset
	assign branchPC = pcPlus2 + {{6{imm[8]}}, imm, 1'b0};

	always_comb
	begin
		if (halt)
			nextPC = pc; // Parked on HLT
		else if (enable && condMet)
			nextPC = isReg ? target : branchPC;
		else
			nextPC = pcPlus2;
	end

	// Branch and HLT decode from disjoint opcodes
	always_comb
	begin
		assert final (!(enable && halt))
			else $error("pcControl: branch enable and halt both high");
	end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps
`include "wiscCpu_settings.svh"

module registerFile
(
	input logic clk,
	input logic reset,
	input logic [$clog2(`REG_COUNT)-1:0] srcReg1,
	input logic [$clog2(`REG_COUNT)-1:0] srcReg2,
	input logic [$clog2(`REG_COUNT)-1:0] dstReg,
	input logic writeReg,
	input logic [`WORD_WIDTH-1:0] dstData,
	output logic [`WORD_WIDTH-1:0] srcData1,
	output logic [`WORD_WIDTH-1:0] srcData2,
	input logic [$clog2(`REG_COUNT)-1:0] dbgReg,
	output logic [`WORD_WIDTH-1:0] dbgData
);

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0; // Whole file cleared
		end
		else if (writeReg)
			regs[dstReg] <= dstData; // R0 writable too
	end

	// Async reads, no bypass
	assign srcData1 = regs[srcReg1];
	assign srcData2 = regs[srcReg2];
	assign dbgData = regs[dbgReg]; // Debug tap

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps
`include "wiscCpu_settings.svh"

module alu
(
	input wiscPkg::aluOpE op,
	input logic [`WORD_WIDTH-1:0] a,
	input logic [`WORD_WIDTH-1:0] b,
	output logic [`WORD_WIDTH-1:0] result,
	output wiscPkg::aluUpdateT update
);

	logic [`WORD_WIDTH:0] addExt, subExt; // One guard bit for saturation
	logic [9:0] redSum;                   // Four bytes need ten bits
	logic [2*`WORD_WIDTH-1:0] rorWide;
	logic overflow;

	// Clamp a 17-bit signed sum to the 16-bit range
	function automatic logic [`WORD_WIDTH-1:0] satWord(input logic [`WORD_WIDTH:0] s);
		if (s[`WORD_WIDTH] != s[`WORD_WIDTH-1])
			satWord = s[`WORD_WIDTH] ? 16'h8000 : 16'h7FFF;
		else
			satWord = s[`WORD_WIDTH-1:0];
	endfunction

	// One PADDSB lane, clamped to -8..7
	function automatic logic [3:0] satNibble(input logic [3:0] x, input logic [3:0] y);
		logic [4:0] s;
		s = {x[3], x} + {y[3], y};
		if (s[4] != s[3])
			satNibble = s[4] ? 4'h8 : 4'h7;
		else
			satNibble = s[3:0];
	endfunction

	////////////////////////////////////////
	// Shared arithmetic
	////////////////////////////////////////

	assign addExt = {a[`WORD_WIDTH-1], a} + {b[`WORD_WIDTH-1], b};
	assign subExt = {a[`WORD_WIDTH-1], a} - {b[`WORD_WIDTH-1], b};
	assign redSum = {{2{a[7]}}, a[7:0]} + {{2{a[15]}}, a[15:8]}
		+ {{2{b[7]}}, b[7:0]} + {{2{b[15]}}, b[15:8]};
	assign rorWide = {a, a} >> b[3:0]; // Low half holds the rotate

	always_comb
	begin
		overflow = 1'b0;
		update.mask = 3'b000; // Flags kept unless the op says otherwise
		case (op)
			wiscPkg::ALU_ADD:
			begin
				result = satWord(addExt);
				overflow = addExt[`WORD_WIDTH] ^ addExt[`WORD_WIDTH-1];
				update.mask = 3'b111;
			end
			wiscPkg::ALU_SUB:
			begin
				result = satWord(subExt);
				overflow = subExt[`WORD_WIDTH] ^ subExt[`WORD_WIDTH-1];
				update.mask = 3'b111;
			end
			wiscPkg::ALU_XOR:
			begin
				result = a ^ b;
				update.mask = 3'b100; // Z only
			end
			wiscPkg::ALU_RED:
				result = {{6{redSum[9]}}, redSum}; // Sign-extended byte sum
			wiscPkg::ALU_SLL:
			begin
				result = a << b[3:0];
				update.mask = 3'b100;
			end
			wiscPkg::ALU_SRA:
			begin
				result = $signed(a) >>> b[3:0];
				update.mask = 3'b100;
			end
			wiscPkg::ALU_ROR:
			begin
				result = rorWide[`WORD_WIDTH-1:0];
				update.mask = 3'b100;
			end
			wiscPkg::ALU_PADDSB:
				result = {satNibble(a[15:12], b[15:12]), satNibble(a[11:8], b[11:8]),
					satNibble(a[7:4], b[7:4]), satNibble(a[3:0], b[3:0])};
		endcase
		update.flags.zero = (result == '0);
		update.flags.overflow = overflow;     // Only set on saturation
		update.flags.negative = result[`WORD_WIDTH-1];
	end

endmodule

// ==== wiscPkg.sv ====
`include "wiscCpu_settings.svh"

package wiscPkg;

	// Top nibble of the instruction
	typedef enum logic [3:0]
	{
		OP_ADD, OP_SUB, OP_XOR, OP_RED,
		OP_SLL, OP_SRA, OP_ROR, OP_PADDSB,
		OP_LW, OP_SW, OP_LLB, OP_LHB,
		OP_B, OP_BR, OP_PCS, OP_HLT
	} opcodeE;

	// Branch condition, bits 11:9 of B and BR
	typedef enum logic [2:0]
	{
		CND_NEQ, CND_EQ, CND_GT, CND_LT,
		CND_GTE, CND_LTE, CND_OVFL, CND_UNCOND
	} condE;

	// Same order as the low opcode bits of the ALU group
	typedef enum logic [2:0]
	{
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_RED,
		ALU_SLL, ALU_SRA, ALU_ROR, ALU_PADDSB
	} aluOpE;

	// Write-back source select
	typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_LLB, WB_LHB, WB_PCS} wbSelE;

	typedef struct packed
	{
		logic zero;
		logic overflow;
		logic negative;
	} flagsT;

	// Mask bits line up with the fields of flagsT
	typedef struct packed
	{
		flagsT flags;
		logic [2:0] mask;
	} aluUpdateT;

	// Decoder output bundle
	typedef struct packed
	{
		logic [$clog2(`REG_COUNT)-1:0] srcReg1;
		logic [$clog2(`REG_COUNT)-1:0] srcReg2;
		logic [$clog2(`REG_COUNT)-1:0] dstReg;
		logic writeReg;
		wbSelE wbSel;
		aluOpE aluOp;
		logic useImm;                 // ALU b from imm, not srcData2
		logic [`WORD_WIDTH-1:0] imm;
		logic setFlags;
		logic memEnable;
		logic memWrite;
		logic branch;                 // B or BR
		logic isReg;                  // BR target from register
		condE cond;
		logic halt;
	} decodeT;

endpackage

// ==== wiscCpu_settings.svh ====
`ifndef WISCCPU_SETTINGS_SVH
`define WISCCPU_SETTINGS_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Data and address width
`define WORD_WIDTH 16

// General registers, R0 included
`define REG_COUNT 16

////////////////////////////////////////
// Memory sizing in 16-bit words
////////////////////////////////////////

`define IMEM_DEPTH 256 // Program store
`define DMEM_DEPTH 256 // Load/store space

`endif
